/* Makefile */
# Verilator run of the SD frame reader testbench
TOP = tb_sd_frame_reader

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; \
	if [ $$rc -ne 0 ] || grep -q "Simulation failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
src/frame_pkg.sv
src/header_parser.sv
src/pixel_packer.sv
src/sector_sequencer.sv
src/sd_frame_reader.sv
tb/sd_card_model.sv
tb/tb_sd_frame_reader.sv

/* src/frame_pkg.sv */
package frame_pkg;

	// --------------------------------------------------
	// sector geometry and search stepping
	// --------------------------------------------------
	localparam int SECTOR_BYTES = 512;                  // bytes per card sector
	localparam int SECTOR_CNT_W = $clog2(SECTOR_BYTES) + 1; // holds 0..512
	localparam logic [31:0] START_SECTOR = 32'd600;     // first sector after reset
	localparam logic [31:0] SCAN_STRIDE = 32'd8;        // candidates every 4k

	// --------------------------------------------------
	// file header layout, byte offsets within sector
	// --------------------------------------------------
	// byte 0 sits in the low lane, so [0] = B2 ... [3] = 89
	localparam logic [3:0][7:0] HEADER_MAGIC = {8'h89, 8'hAA, 8'h76, 8'hB2};
	localparam int WIDTH_OFFSET = 4;                    // 4 bytes, little endian
	localparam int FRAME_LEN_OFFSET = 68;               // 4 bytes, little endian
	localparam int MATCH_BYTE = 499;                    // decision point in sector
	localparam logic [31:0] PIXEL_OFFSET = 32'd84;      // first pixel byte in file

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	// one byte from the card, 10 bits
	typedef struct packed {
		logic [7:0] data;       // read data
		logic       valid;      // data strobe
		logic       sec_end;    // one cycle after the last byte
	} sd_byte_t;

	// captured header fields, 65 bits
	typedef struct packed {
		logic        match;     // magic and width agree
		logic [31:0] width;     // image width from file
		logic [31:0] frame_len; // pixel bytes in frame
	} header_t;

	// status code seen by the front panel
	typedef enum logic [3:0] {
		STATUS_INIT   = 4'd0,   // card still initialising
		STATUS_IDLE   = 4'd1,   // waiting for find
		STATUS_SEARCH = 4'd2,   // scanning for the file
		STATUS_READ   = 4'd3    // streaming pixels
	} status_t;

endpackage

/* src/header_parser.sv */
`timescale 1ns/1ps

module header_parser (
	input  logic                clk,
	input  logic                rst,
	input  logic                scanning,   // sequencer is in search
	input  frame_pkg::sd_byte_t sd_byte,
	input  logic [31:0]         bmp_width,  // width we are looking for
	output frame_pkg::header_t  header
);
	import frame_pkg::*;

	logic [SECTOR_CNT_W-1:0] byte_cnt;      // byte index within sector
	logic [SECTOR_CNT_W-1:0] width_idx;     // byte_cnt relative to width field
	logic [SECTOR_CNT_W-1:0] len_idx;       // byte_cnt relative to length field
	logic [3:0][7:0]         magic;         // first four bytes of sector
	logic [31:0]             width;
	logic [31:0]             frame_len;
	logic                    match;
	logic                    magic_ok;
	logic                    byte_in;

	assign byte_in = scanning && sd_byte.valid;
	assign width_idx = byte_cnt - SECTOR_CNT_W'(WIDTH_OFFSET);  // wraps high below offset
	assign len_idx = byte_cnt - SECTOR_CNT_W'(FRAME_LEN_OFFSET);
	assign magic_ok = (magic == HEADER_MAGIC);

	// --------------------------------------------------
	// byte counter, restarts every sector
	// --------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			byte_cnt <= '0;
		else if (!scanning)
			byte_cnt <= '0;                     // idle between scans
		else if (sd_byte.sec_end)
			byte_cnt <= '0;                     // next candidate sector
		else if (sd_byte.valid)
			byte_cnt <= byte_cnt + 1'b1;
	end

	// field capture at fixed offsets
	// fields hold after the scan so the packer still sees frame_len
	always_ff @(posedge clk)
	begin
		if (byte_in)
		begin
			if (byte_cnt < SECTOR_CNT_W'(4))
				magic[byte_cnt[1:0]] <= sd_byte.data;           // magic bytes 0..3
			if (width_idx < SECTOR_CNT_W'(4))
				width[8*width_idx[1:0] +: 8] <= sd_byte.data;  // lsb first
			if (len_idx < SECTOR_CNT_W'(4))
				frame_len[8*len_idx[1:0] +: 8] <= sd_byte.data;
		end
	end

	// --------------------------------------------------
	// match decision at MATCH_BYTE
	// --------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			match <= 1'b0;
		else if (!scanning)
			match <= 1'b0;                      // dropped once search ends
		else if (byte_in && byte_cnt == SECTOR_CNT_W'(MATCH_BYTE))
			match <= magic_ok && (width == bmp_width);
	end

	assign header = '{match: match, width: width, frame_len: frame_len};

	// card never sends more than one sector between end pulses
	a_byte_cnt_range: assert property (@(posedge clk) disable iff (rst)
		byte_cnt <= SECTOR_CNT_W'(SECTOR_BYTES))
		else $error("header_parser: byte count past sector size");

endmodule

/* src/pixel_packer.sv */
`timescale 1ns/1ps

module pixel_packer (
	input  logic                clk,
	input  logic                rst,
	input  logic                reading,     // sequencer streams the file
	input  frame_pkg::sd_byte_t sd_byte,
	input  logic [31:0]         frame_len,   // pixel bytes in the frame
	output logic                pixel_wr_en,
	output logic [15:0]         pixel_data,
	output logic                window_done
);
	import frame_pkg::*;

	logic [31:0] file_cnt;      // file byte index
	logic [31:0] window_end;    // first byte past the pixels
	logic        pixel_byte;    // current byte is inside window
	logic        pair_hi;       // next pixel byte is the high half

	assign window_end = PIXEL_OFFSET + frame_len;
	assign pixel_byte = reading && sd_byte.valid &&
		(file_cnt >= PIXEL_OFFSET) && (file_cnt < window_end);
	assign window_done = (file_cnt >= window_end);   // sequencer checks at sector end

	// --------------------------------------------------
	// file byte counter
	// --------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			file_cnt <= '0;
		else if (!reading)
			file_cnt <= '0;                         // start of file on next read
		else if (sd_byte.valid)
			file_cnt <= file_cnt + 32'd1;
	end

	// byte pairing, low half first
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pair_hi <= 1'b0;
			pixel_wr_en <= 1'b0;
		end
		else
		begin
			pixel_wr_en <= pixel_byte && pair_hi;   // one pulse per word
			if (!reading)
				pair_hi <= 1'b0;
			else if (pixel_byte)
				pair_hi <= ~pair_hi;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pixel_byte && !pair_hi)
			pixel_data[7:0] <= sd_byte.data;        // first byte of pair
		else if (pixel_byte && pair_hi)
			pixel_data[15:8] <= sd_byte.data;       // second byte completes word
	end

	// a pair always needs two card bytes
	a_wr_en_single: assert property (@(posedge clk) disable iff (rst)
		pixel_wr_en |=> !pixel_wr_en)
		else $error("pixel_packer: write enable held two cycles");

endmodule

/* src/sd_frame_reader.sv */
`timescale 1ns/1ps

module sd_frame_reader (
	input  logic                clk,
	input  logic                rst,
	input  logic                sd_init_done,     // card ready
	input  logic                find,             // start search pulse
	input  logic [31:0]         bmp_width,        // width to match
	input  frame_pkg::sd_byte_t sd_byte,          // card read data
	input  logic                write_ack,        // frame store answer
	output frame_pkg::status_t  status,
	output logic                sd_sec_read,      // sector request level
	output logic [31:0]         sd_sec_read_addr,
	output logic                write_req,        // frame store request
	output logic                pixel_wr_en,
	output logic [15:0]         pixel_data
);
	import frame_pkg::*;

	header_t header;        // parser result
	logic    scanning;      // search phase
	logic    reading;       // read phase
	logic    window_done;   // last pixel byte passed

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	sector_sequencer u_sequencer (
		.clk              (clk),
		.rst              (rst),
		.sd_init_done     (sd_init_done),
		.find             (find),
		.sd_byte          (sd_byte),
		.header           (header),
		.window_done      (window_done),
		.write_ack        (write_ack),
		.status           (status),
		.sd_sec_read      (sd_sec_read),
		.sd_sec_read_addr (sd_sec_read_addr),
		.write_req        (write_req),
		.scanning         (scanning),
		.reading          (reading)
	);

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	header_parser u_parser (
		.clk       (clk),
		.rst       (rst),
		.scanning  (scanning),
		.sd_byte   (sd_byte),
		.bmp_width (bmp_width),
		.header    (header)
	);

	pixel_packer u_packer (
		.clk         (clk),
		.rst         (rst),
		.reading     (reading),
		.sd_byte     (sd_byte),
		.frame_len   (header.frame_len),  // held from the matching sector
		.pixel_wr_en (pixel_wr_en),
		.pixel_data  (pixel_data),
		.window_done (window_done)
	);

endmodule

/* src/sector_sequencer.sv */
`timescale 1ns/1ps

module sector_sequencer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 sd_init_done,
	input  logic                 find,            // start a search
	input  frame_pkg::sd_byte_t  sd_byte,
	input  frame_pkg::header_t   header,
	input  logic                 window_done,     // last pixel byte seen
	input  logic                 write_ack,
	output frame_pkg::status_t   status,
	output logic                 sd_sec_read,
	output logic [31:0]          sd_sec_read_addr,
	output logic                 write_req,
	output logic                 scanning,
	output logic                 reading
);
	import frame_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SEARCH,
		ST_HANDSHAKE,   // four-phase write request
		ST_READ,
		ST_END
	} state_t;

	state_t state;

	assign scanning = (state == ST_SEARCH);   // parser active
	assign reading = (state == ST_READ);      // packer active

	// --------------------------------------------------
	// control FSM
	// --------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			status <= STATUS_INIT;
			sd_sec_read <= 1'b0;
			sd_sec_read_addr <= START_SECTOR;
			write_req <= 1'b0;
		end
		else if (!sd_init_done)
		begin
			state <= ST_IDLE;                   // card lost, abandon everything
			status <= STATUS_INIT;
			sd_sec_read <= 1'b0;
			write_req <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					status <= STATUS_IDLE;
					sd_sec_read <= 1'b0;
					if (find)
					begin
						state <= ST_SEARCH;
						// candidates sit on 8-sector boundaries
						sd_sec_read_addr <= sd_sec_read_addr & ~(SCAN_STRIDE - 32'd1);
					end
				end
				ST_SEARCH:
				begin
					status <= STATUS_SEARCH;
					if (sd_byte.sec_end)
					begin
						sd_sec_read <= 1'b0;        // one low cycle between sectors
						if (header.match)
						begin
							state <= ST_HANDSHAKE;
							write_req <= 1'b1;      // ask the frame store for a slot
						end
						else
							sd_sec_read_addr <= sd_sec_read_addr + SCAN_STRIDE;
					end
					else
						sd_sec_read <= 1'b1;
				end
				ST_HANDSHAKE:
				begin
					if (write_req && write_ack)
						write_req <= 1'b0;          // phase 3
					else if (!write_req && !write_ack)
						state <= ST_READ;           // phase 4 done, file starts here
				end
				ST_READ:
				begin
					status <= STATUS_READ;
					if (sd_byte.sec_end)
					begin
						sd_sec_read <= 1'b0;
						if (window_done)
							state <= ST_END;        // sector held the last pixel
						else
							sd_sec_read_addr <= sd_sec_read_addr + 32'd1;
					end
					else
						sd_sec_read <= 1'b1;
				end
				ST_END:
				begin
					status <= STATUS_IDLE;
					sd_sec_read <= 1'b0;
					state <= ST_IDLE;
				end
				default:
				begin
					state <= ST_IDLE;
					sd_sec_read <= 1'b0;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// protocol checks
	// --------------------------------------------------
	// request only withdrawn after the store answered, or on init loss
	a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
		$fell(write_req) |-> $past(write_ack) || !$past(sd_init_done))
		else $error("sector_sequencer: write_req dropped before write_ack");

	// card latches the address for the whole sector
	a_addr_stable: assert property (@(posedge clk) disable iff (rst)
		sd_sec_read |=> !sd_sec_read || $stable(sd_sec_read_addr))
		else $error("sector_sequencer: address moved during sector read");

endmodule

/* tb/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model (
	input  logic                clk,
	input  logic                sd_sec_read,       // level request from the reader
	input  logic [31:0]         sd_sec_read_addr,
	output frame_pkg::sd_byte_t sd_byte
);
	import frame_pkg::*;

	logic [7:0]  image [int unsigned];                // sparse card, keyed by byte address
	logic [31:0] gap_lfsr = 32'hca9fb302;             // idle gap source

	// galois lfsr, one step per bit taken
	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[6:0], gap_lfsr[0]};
			if (gap_lfsr[0])
				gap_lfsr = (gap_lfsr >> 1) ^ 32'h80200003;
			else
				gap_lfsr = gap_lfsr >> 1;
		end
		return r;
	endfunction

	task automatic load_byte(input int unsigned addr, input logic [7:0] data);
		image[addr] = data;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;                                           // drive just after the edge
	endtask

	// --------------------------------------------------
	// one sector, 512 bytes then the end pulse
	// --------------------------------------------------
	task automatic serve_sector(input logic [31:0] sector);
		logic [7:0]  gap;
		int unsigned addr;
		for (int i = 0; i < SECTOR_BYTES; i++)
		begin
			addr = sector * 32'(SECTOR_BYTES) + i;
			gap = lfsr_bits(2);                       // 0..3 idle cycles
			sd_byte = '0;
			repeat (gap) next_cycle();
			sd_byte.data = image.exists(addr) ? image[addr] : 8'h00;   // zero sectors elsewhere
			sd_byte.valid = 1'b1;
			next_cycle();
		end
		sd_byte = '{data: 8'h00, valid: 1'b0, sec_end: 1'b1};
		next_cycle();
		sd_byte = '0;
	endtask

	initial
	begin
		sd_byte = '0;
		forever
		begin
			next_cycle();
			if (sd_sec_read)
			begin
				serve_sector(sd_sec_read_addr);     // address latched at request
				while (sd_sec_read)
					next_cycle();                   // wait for the request to drop
			end
		end
	end

endmodule

/* tb/tb_sd_frame_reader.sv */
`timescale 1ns/1ps

module tb_sd_frame_reader;
	import frame_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam logic [31:0] BMP_WIDTH = 32'd320;
	localparam logic [31:0] FRAME_LEN = 32'd1000;                 // file spans three sectors
	localparam logic [31:0] MAGIC_LE = 32'h89AA76B2;              // B2 76 AA 89 from byte 0
	localparam int WATCHDOG_CYCLES = 2 * 6 * 512 * 4 + 1000;      // six sectors, worst gaps, x2

	logic        clk;
	logic        rst;
	logic        sd_init_done;
	logic        find;
	logic [31:0] bmp_width;
	sd_byte_t    sd_byte;
	logic        write_ack;
	status_t     status;
	logic        sd_sec_read;
	logic [31:0] sd_sec_read_addr;
	logic        write_req;
	logic        pixel_wr_en;
	logic [15:0] pixel_data;

	logic [31:0] lfsr_state = 32'hca9fb302;
	logic [31:0] expected_addr [$];          // search then file sectors
	logic [15:0] expected_words [$];         // low byte first
	int          mismatches = 0;
	int          faults = 0;
	int          words = 0;
	int          requests = 0;
	int          handshakes = 0;
	int          since_find = 0;             // cycles since find
	logic        handshake_done = 1'b0;
	logic        quiet = 1'b0;               // DUT must sit idle
	logic        last_read = 1'b0;
	logic        last_req = 1'b0;
	logic        last_sec_end = 1'b0;

	sd_frame_reader sd_frame_reader_i (.*);
	sd_card_model card (.*);

	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[6:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return r;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
		mismatches = mismatches + 1;
		$display("[ERROR] %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
	endtask

	task automatic protocol_fault(input string what);
		faults = faults + 1;
		$display("%0d ns: %s", $time, what);
	endtask

	task automatic put_header(input int sector, input logic [31:0] width);
		int unsigned base;
		base = sector * SECTOR_BYTES;
		for (int i = 0; i < 4; i++)
		begin
			card.load_byte(base + i, MAGIC_LE[8*i +: 8]);
			card.load_byte(base + WIDTH_OFFSET + i, width[8*i +: 8]);       // lsb first
			card.load_byte(base + FRAME_LEN_OFFSET + i, FRAME_LEN[8*i +: 8]);
		end
	endtask

	// --------------------------------------------------
	// image and expected results
	// --------------------------------------------------
	task automatic build_image();
		logic [7:0] pix;
		logic [7:0] low;
		low = 8'h00;
		put_header(608, BMP_WIDTH + 32'd1);      // decoy, width one off
		put_header(616, BMP_WIDTH);
		for (int i = 0; i < int'(FRAME_LEN); i++)
		begin
			pix = lfsr_bits(8);
			card.load_byte(616 * SECTOR_BYTES + PIXEL_OFFSET + i, pix);
			if (i % 2 == 0)
				low = pix;
			else
				expected_words.push_back({pix, low});
		end
		expected_addr.push_back(32'd600);        // aligned start, empty
		expected_addr.push_back(32'd608);
		expected_addr.push_back(32'd616);        // match
		expected_addr.push_back(32'd616);        // file from here
		expected_addr.push_back(32'd617);
		expected_addr.push_back(32'd618);
	endtask

	task automatic wait_status(input status_t s);
		while (status != s)
			next_cycle();
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// four-phase frame store, slow on purpose
	initial
	begin
		write_ack = 1'b0;
		forever
		begin
			next_cycle();
			if (write_req)
			begin
				repeat (3) next_cycle();
				write_ack = 1'b1;
				while (write_req)
					next_cycle();
				repeat (4) next_cycle();
				write_ack = 1'b0;
				handshake_done = 1'b1;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired, DUT did not finish the frame in %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// --------------------------------------------------
	// checks, sampled mid cycle
	// --------------------------------------------------
	always @(negedge clk)
	begin
		logic [31:0] want_addr;
		logic [15:0] want_word;
		status_t     want_status;
		since_find = find ? 0 : since_find + 1;
		if (!sd_init_done)
		begin
			a_init_status: assert (status == STATUS_INIT)
				else mismatch("status", 32'(status), 32'(STATUS_INIT));
			a_init_quiet: assert (!sd_sec_read && !write_req && !pixel_wr_en)
				else protocol_fault("request or write enable active before card init");
		end
		if (sd_sec_read && !last_read)            // new sector request
		begin
			requests = requests + 1;
			a_extra_request: assert (expected_addr.size() != 0)
				else protocol_fault("sector requested after the last file sector");
			if (expected_addr.size() != 0)
			begin
				want_addr = expected_addr.pop_front();
				a_sector_addr: assert (sd_sec_read_addr == want_addr)
					else mismatch("sd_sec_read_addr", sd_sec_read_addr, want_addr);
			end
			if (requests == 1)
				a_find_latency: assert (since_find == 2)
					else mismatch("cycles from find to request", 32'(since_find), 32'd2);
			if (requests > 3)
				a_read_after_ack: assert (handshake_done)
					else protocol_fault("file read requested before write handshake finished");
		end
		if (sd_sec_read)
		begin
			want_status = handshake_done ? STATUS_READ : STATUS_SEARCH;
			a_busy_status: assert (status == want_status)
				else mismatch("status", 32'(status), 32'(want_status));
		end
		if (write_req && !last_req)
		begin
			handshakes = handshakes + 1;
			a_req_after_match: assert (requests == 3)
				else mismatch("sector requests before write_req", 32'(requests), 32'd3);
			a_req_latency: assert (last_sec_end)
				else protocol_fault("write_req not raised one cycle after matching end pulse");
		end
		if (!write_req && last_req)
			a_req_fall: assert (write_ack)
				else protocol_fault("write_req dropped before write_ack rose");
		if (write_req)
			a_req_alone: assert (!sd_sec_read)
				else protocol_fault("sector read active during write handshake");
		if (pixel_wr_en)
		begin
			a_extra_word: assert (expected_words.size() != 0)
				else protocol_fault("pixel word written past the end of the frame");
			if (expected_words.size() != 0)
			begin
				want_word = expected_words.pop_front();
				a_pixel: assert (pixel_data == want_word)
					else mismatch("pixel_data", 32'(pixel_data), 32'(want_word));
				words = words + 1;
			end
		end
		if (quiet)
		begin
			a_idle_status: assert (status == STATUS_IDLE)
				else mismatch("status", 32'(status), 32'(STATUS_IDLE));
			a_idle_read: assert (!sd_sec_read)
				else mismatch("sd_sec_read", 32'(sd_sec_read), 32'd0);
			a_idle_wr: assert (!pixel_wr_en)
				else mismatch("pixel_wr_en", 32'(pixel_wr_en), 32'd0);
		end
		last_read = sd_sec_read;
		last_req = write_req;
		last_sec_end = sd_byte.sec_end;
	end

	initial
	begin
		rst = 1'b1;
		sd_init_done = 1'b0;
		find = 1'b0;
		bmp_width = BMP_WIDTH;
		build_image();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (4) next_cycle();                 // card still initialising
		sd_init_done = 1'b1;
		repeat (2) next_cycle();
		quiet = 1'b1;
		repeat (6) next_cycle();
		quiet = 1'b0;
		find = 1'b1;                             // single cycle pulse
		next_cycle();
		find = 1'b0;
		wait_status(STATUS_READ);
		wait_status(STATUS_IDLE);
		quiet = 1'b1;                            // no traffic until next find
		repeat (40) next_cycle();
		a_all_sectors: assert (expected_addr.size() == 0)
			else mismatch("sector requests missing", 32'(expected_addr.size()), 32'd0);
		a_word_count: assert (words == int'(FRAME_LEN) / 2)
			else mismatch("pixel words", 32'(words), FRAME_LEN / 32'd2);
		a_one_handshake: assert (handshakes == 1)
			else mismatch("write_req handshakes", 32'(handshakes), 32'd1);
		$display("%0d value mismatches, %0d protocol faults, %0d pixel words compared",
			mismatches, faults, words);
		if (mismatches == 0 && faults == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
